// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`default_nettype none

// core datapath
`define CPU_DATA_W 16 // machine word
`define CPU_ADDR_W 12 // word address into unified memory
`define CPU_MEM_DEPTH 4096

// host bus
`define CPU_AXI_ADDR_W 16
`define CPU_AXI_DATA_W 32

// host byte address map
`define CPU_REG_CTRL 16'h0000 // bit 0 starts the core
`define CPU_REG_STATUS 16'h0004
`define CPU_REG_LED 16'h0008
`define CPU_REG_GPR 16'h0010 // ax..dx at 0x10, 0x14, 0x18, 0x1c
`define CPU_MEM_WIN 16'h2000 // word n at base + 4n

`default_nettype wire

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef enum logic [15:0] {
		OP_NOP = 16'h0000,
		OP_MOVRR = 16'h0007, // dst <= src
		OP_MOVI = 16'h0008, // reg <= par2
		OP_OUT = 16'h000A, // led <= dx
		OP_ADD = 16'h000C,
		OP_ADC = 16'h000D,
		OP_SUB = 16'h000E,
		OP_SUC = 16'h000F,
		OP_CMP = 16'h0014,
		OP_AND = 16'h0015,
		OP_NOT = 16'h0016,
		OP_OR = 16'h0018,
		OP_SHL = 16'h0019,
		OP_SHR = 16'h001A,
		OP_XOR = 16'h001B,
		OP_HLT = 16'h001D,
		OP_JC = 16'h0021,
		OP_JNC = 16'h0022,
		OP_JZ = 16'h0023,
		OP_JNZ = 16'h0024,
		OP_STA = 16'h002A, // mem[par2] <= reg
		OP_LDA = 16'h002B, // reg <= mem[par2]
		OP_JMP = 16'h0031
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SUC,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
		ALU_SHL, ALU_SHR, ALU_PASS
	} aluOpT;

	typedef enum logic [1:0] {REG_AX, REG_BX, REG_CX, REG_DX} regSelT;

	typedef struct packed {
		logic cf; // carry, or borrow after a subtract
		logic zf;
		logic of; // signed overflow
	} flagsT;

endpackage

`default_nettype wire

// ==== aluUnit.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module aluUnit (
	input logic [`CPU_DATA_W-1:0] a,
	input logic [`CPU_DATA_W-1:0] b,
	input cpu_pkg::aluOpT op,
	input cpu_pkg::flagsT flagsIn,
	output logic [`CPU_DATA_W-1:0] result,
	output cpu_pkg::flagsT flagsOut
);
	import cpu_pkg::*;

	localparam int W = `CPU_DATA_W;

	logic carryIn;
	logic [W:0] sum;
	logic [W:0] diff;

	assign carryIn = (op == ALU_ADC || op == ALU_SUC) ? flagsIn.cf : 1'b0;
	assign sum = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, carryIn};
	assign diff = {1'b0, a} - {1'b0, b} - {{W{1'b0}}, carryIn}; // bit W is the borrow

	always_comb begin
		result = b;
		flagsOut = flagsIn; // logic ops keep the flags
		case (op)
			ALU_ADD, ALU_ADC: begin
				result = sum[W-1:0];
				flagsOut.cf = sum[W];
				flagsOut.zf = (sum[W-1:0] == '0);
				flagsOut.of = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
			end
			ALU_SUB, ALU_SUC: begin
				result = diff[W-1:0];
				flagsOut.cf = diff[W];
				flagsOut.zf = (diff[W-1:0] == '0);
				flagsOut.of = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			ALU_NOT:
				result = ~a;
			ALU_SHL:
				result = {a[W-2:0], 1'b0};
			ALU_SHR:
				result = {1'b0, a[W-1:1]}; // logical shift
			ALU_PASS:
				result = b; // register move
			default:
				result = b;
		endcase
	end

endmodule

`default_nettype wire

// ==== progMem.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module progMem (
	input logic clk,
	input logic [`CPU_ADDR_W-1:0] fetchAddr0,
	input logic [`CPU_ADDR_W-1:0] fetchAddr1,
	input logic [`CPU_ADDR_W-1:0] fetchAddr2,
	output logic [`CPU_DATA_W-1:0] fetchData0,
	output logic [`CPU_DATA_W-1:0] fetchData1,
	output logic [`CPU_DATA_W-1:0] fetchData2,
	input logic [`CPU_ADDR_W-1:0] rdAddr,
	output logic [`CPU_DATA_W-1:0] rdData,
	input logic coreWrEn,
	input logic [`CPU_ADDR_W-1:0] coreWrAddr,
	input logic [`CPU_DATA_W-1:0] coreWrData,
	input logic hostWrEn,
	input logic [`CPU_ADDR_W-1:0] hostWrAddr,
	input logic [`CPU_DATA_W-1:0] hostWrData
);

	logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];
	logic hostClash;

	// opcode, par1 and par2 all visible in the same cycle
	assign fetchData0 = mem[fetchAddr0];
	assign fetchData1 = mem[fetchAddr1];
	assign fetchData2 = mem[fetchAddr2];

	assign hostClash = coreWrEn && (coreWrAddr == hostWrAddr); // core takes the word

	always_ff @(posedge clk) begin
		rdData <= mem[rdAddr]; // data port is one cycle late
		if (coreWrEn)
			mem[coreWrAddr] <= coreWrData;
		if (hostWrEn && !hostClash)
			mem[hostWrAddr] <= hostWrData;
	end

endmodule

`default_nettype wire

// ==== hostCtrl.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module hostCtrl (
	input logic clk,
	input logic rst,
	input logic [`CPU_AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`CPU_AXI_DATA_W-1:0] wdata,
	input logic [`CPU_AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`CPU_AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`CPU_AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic start,
	input logic busy,
	input logic halted,
	input cpu_pkg::flagsT flags,
	input logic [7:0] led,
	output cpu_pkg::regSelT regSel,
	input logic [`CPU_DATA_W-1:0] regData,
	output logic hostWrEn,
	output logic [`CPU_ADDR_W-1:0] hostWrAddr,
	output logic [`CPU_DATA_W-1:0] hostWrData
);
	import cpu_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic idle;
	logic wrAccept;
	logic rdAccept;
	logic winHit;
	logic gprHit;
	logic [`CPU_AXI_ADDR_W-1:0] winOff;
	logic [`CPU_AXI_DATA_W-1:0] rdValue;

	assign idle = !bvalid && !rvalid; // one transaction in flight
	assign wrAccept = idle && awvalid && wvalid;
	assign rdAccept = idle && arvalid && !(awvalid && wvalid); // write wins a tie
	assign awready = wrAccept;
	assign wready = wrAccept;
	assign arready = rdAccept;
	assign rresp = RESP_OKAY;

	// program-load window decode
	assign winOff = awaddr - `CPU_MEM_WIN;
	assign winHit = (awaddr >= `CPU_MEM_WIN) && (winOff[`CPU_AXI_ADDR_W-1:2] < `CPU_MEM_DEPTH);

	assign gprHit = (araddr >= `CPU_REG_GPR) && (araddr < `CPU_REG_GPR + 16)
		&& (araddr[1:0] == 2'b00);
	assign regSel = regSelT'(araddr[3:2]); // word offset picks ax..dx

	always_comb begin
		rdValue = '0; // ctrl and unmapped read as zero
		if (araddr == `CPU_REG_STATUS) begin
			rdValue[0] = busy;
			rdValue[1] = halted;
			rdValue[4] = flags.cf;
			rdValue[5] = flags.zf;
			rdValue[6] = flags.of;
		end else if (araddr == `CPU_REG_LED) begin
			rdValue[7:0] = led;
		end else if (gprHit) begin
			rdValue[`CPU_DATA_W-1:0] = regData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			rvalid <= 1'b0;
			start <= 1'b0;
			hostWrEn <= 1'b0;
		end else begin
			start <= wrAccept && (awaddr == `CPU_REG_CTRL) && wstrb[0] && wdata[0]; // one-cycle pulse
			hostWrEn <= wrAccept && winHit && !busy && (&wstrb[1:0]);
			if (wrAccept) begin
				bvalid <= 1'b1;
				bresp <= (winHit && busy) ? RESP_SLVERR : RESP_OKAY; // no loads while running
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rdAccept) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wrAccept) begin
			hostWrAddr <= winOff[`CPU_ADDR_W+1:2]; // byte to word address
			hostWrData <= wdata[`CPU_DATA_W-1:0];
		end
		if (rdAccept) begin
			rdata <= rdValue;
		end
	end

endmodule

`default_nettype wire

// ==== cpuCore.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module cpuCore (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	output logic halted,
	output cpu_pkg::flagsT flags,
	output logic [7:0] led,
	input cpu_pkg::regSelT regSel,
	output logic [`CPU_DATA_W-1:0] regData,
	output logic [`CPU_ADDR_W-1:0] fetchAddr0,
	output logic [`CPU_ADDR_W-1:0] fetchAddr1,
	output logic [`CPU_ADDR_W-1:0] fetchAddr2,
	input logic [`CPU_DATA_W-1:0] fetchData0,
	input logic [`CPU_DATA_W-1:0] fetchData1,
	input logic [`CPU_DATA_W-1:0] fetchData2,
	output logic [`CPU_ADDR_W-1:0] rdAddr,
	input logic [`CPU_DATA_W-1:0] rdData,
	output logic coreWrEn,
	output logic [`CPU_ADDR_W-1:0] coreWrAddr,
	output logic [`CPU_DATA_W-1:0] coreWrData,
	output logic [`CPU_DATA_W-1:0] aluA,
	output logic [`CPU_DATA_W-1:0] aluB,
	output cpu_pkg::aluOpT aluOp,
	input logic [`CPU_DATA_W-1:0] aluResult,
	input cpu_pkg::flagsT aluFlags
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0] regFile [4]; // ax, bx, cx, dx
	logic [`CPU_ADDR_W-1:0] pc;
	logic ldaWait; // second cycle of lda
	opcodeT opcode;
	logic [`CPU_DATA_W-1:0] par1;
	logic [`CPU_DATA_W-1:0] par2;
	logic unaryOp;
	regSelT dstSel;
	regSelT srcSel;
	logic flagLoad;
	logic regLoad;
	logic [`CPU_ADDR_W-1:0] pcPlus1, pcPlus2, pcPlus3;
	logic [`CPU_ADDR_W-1:0] jumpTarget;
	logic [`CPU_ADDR_W-1:0] pcNext;

	assign pcPlus1 = pc + 1'b1;
	assign pcPlus2 = pc + 2'd2;
	assign pcPlus3 = pc + 2'd3;
	assign fetchAddr0 = pc;
	assign fetchAddr1 = pcPlus1;
	assign fetchAddr2 = pcPlus2;

	assign opcode = opcodeT'(fetchData0);
	assign par1 = fetchData1;
	assign par2 = fetchData2;
	assign jumpTarget = par1[`CPU_ADDR_W-1:0]; // absolute

	// single-register ops name their register in par1[1:0]
	assign unaryOp = opcode inside {OP_NOT, OP_SHL, OP_SHR};
	assign dstSel = unaryOp ? regSelT'(par1[1:0]) : regSelT'(par1[3:2]);
	assign srcSel = regSelT'(par1[1:0]);

	assign aluA = regFile[dstSel];
	assign aluB = regFile[srcSel];
	assign regData = regFile[regSel];

	assign rdAddr = par2[`CPU_ADDR_W-1:0];
	assign coreWrAddr = par2[`CPU_ADDR_W-1:0];
	assign coreWrData = regFile[srcSel];
	assign coreWrEn = busy && (opcode == OP_STA);

	always_comb begin
		aluOp = ALU_PASS;
		case (opcode)
			OP_ADD: aluOp = ALU_ADD;
			OP_ADC: aluOp = ALU_ADC;
			OP_SUB, OP_CMP: aluOp = ALU_SUB;
			OP_SUC: aluOp = ALU_SUC;
			OP_AND: aluOp = ALU_AND;
			OP_OR: aluOp = ALU_OR;
			OP_XOR: aluOp = ALU_XOR;
			OP_NOT: aluOp = ALU_NOT;
			OP_SHL: aluOp = ALU_SHL;
			OP_SHR: aluOp = ALU_SHR;
			default: aluOp = ALU_PASS;
		endcase
	end

	always_comb begin
		flagLoad = 1'b0;
		regLoad = 1'b0;
		pcNext = pcPlus1; // nop, out and unknown opcodes
		case (opcode)
			OP_MOVRR, OP_ADD, OP_ADC, OP_SUB, OP_SUC,
			OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHL, OP_SHR: begin
				flagLoad = 1'b1; // alu returns old flags for non-arith ops
				regLoad = 1'b1;
				pcNext = pcPlus2;
			end
			OP_CMP: begin
				flagLoad = 1'b1;
				pcNext = pcPlus2;
			end
			OP_MOVI, OP_STA:
				pcNext = pcPlus3;
			OP_LDA:
				pcNext = ldaWait ? pcPlus3 : pc;
			OP_JMP:
				pcNext = jumpTarget;
			OP_JC:
				pcNext = flags.cf ? jumpTarget : pcPlus2;
			OP_JNC:
				pcNext = !flags.cf ? jumpTarget : pcPlus2;
			OP_JZ:
				pcNext = flags.zf ? jumpTarget : pcPlus2;
			OP_JNZ:
				pcNext = !flags.zf ? jumpTarget : pcPlus2;
			OP_HLT:
				pcNext = pc;
			default:
				pcNext = pcPlus1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			halted <= 1'b0;
			pc <= '0;
			flags <= '0;
			led <= '0;
			ldaWait <= 1'b0;
			regFile <= '{default: '0};
		end else if (start) begin
			busy <= 1'b1; // restart from address 0
			halted <= 1'b0;
			pc <= '0;
			flags <= '0;
			ldaWait <= 1'b0;
			regFile <= '{default: '0};
		end else if (busy) begin
			pc <= pcNext;
			if (flagLoad)
				flags <= aluFlags;
			if (regLoad)
				regFile[dstSel] <= aluResult;
			case (opcode)
				OP_MOVI:
					regFile[srcSel] <= par2;
				OP_LDA: begin
					ldaWait <= !ldaWait;
					if (ldaWait)
						regFile[srcSel] <= rdData; // read issued last cycle
				end
				OP_OUT:
					led <= regFile[REG_DX][7:0];
				OP_HLT: begin
					busy <= 1'b0;
					halted <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== cpuTop.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module cpuTop (
	input logic clk,
	input logic rst,
	input logic [`CPU_AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [`CPU_AXI_DATA_W-1:0] wdata,
	input logic [`CPU_AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`CPU_AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [`CPU_AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [7:0] led
);
	import cpu_pkg::*;

	logic start, busy, halted;
	flagsT flags, aluFlags;
	regSelT regSel;
	logic [`CPU_DATA_W-1:0] regData;
	logic hostWrEn, coreWrEn;
	logic [`CPU_ADDR_W-1:0] hostWrAddr, coreWrAddr, rdAddr;
	logic [`CPU_DATA_W-1:0] hostWrData, coreWrData, rdData;
	logic [`CPU_ADDR_W-1:0] fetchAddr0, fetchAddr1, fetchAddr2;
	logic [`CPU_DATA_W-1:0] fetchData0, fetchData1, fetchData2;
	logic [`CPU_DATA_W-1:0] aluA, aluB, aluResult;
	aluOpT aluOp;

	hostCtrl uHost (
		.clk, .rst,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.start, .busy, .halted, .flags, .led, .regSel, .regData,
		.hostWrEn, .hostWrAddr, .hostWrData
	);

	cpuCore uCore (
		.clk, .rst, .start, .busy, .halted, .flags, .led, .regSel, .regData,
		.fetchAddr0, .fetchAddr1, .fetchAddr2, .fetchData0, .fetchData1, .fetchData2,
		.rdAddr, .rdData, .coreWrEn, .coreWrAddr, .coreWrData,
		.aluA, .aluB, .aluOp, .aluResult, .aluFlags
	);

	aluUnit uAlu (
		.a(aluA), .b(aluB), .op(aluOp), .flagsIn(flags),
		.result(aluResult), .flagsOut(aluFlags)
	);

	progMem uMem (
		.clk,
		.fetchAddr0, .fetchAddr1, .fetchAddr2, .fetchData0, .fetchData1, .fetchData2,
		.rdAddr, .rdData, .coreWrEn, .coreWrAddr, .coreWrData,
		.hostWrEn, .hostWrAddr, .hostWrData
	);

endmodule

`default_nettype wire

// ==== cpu_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuChk (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic halted,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic [7:0] led
);

	int failCount = 0; // assertion failures so far

	busyHaltedExclusive: assert property (@(posedge clk) disable iff (rst) !(busy && halted))
		else begin
			$error("busy and halted are both high");
			failCount++;
		end

	bvalidHeld: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			failCount++;
		end

	rvalidHeld: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			failCount++;
		end

	// outputs cleared one cycle into reset
	resetClears: assert property (@(posedge clk) rst |=> (led == 8'h00) && !busy)
		else begin
			$error("led or busy not low after reset");
			failCount++;
		end

endmodule

bind cpuTop cpuChk uChk (.clk, .rst, .busy, .halted, .bvalid, .bready, .rvalid, .rready, .led);

`default_nettype wire

// ==== cpu_tb.sv ====
`timescale 1ns/1ns
`include "cpu_defines.svh"
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	localparam int HS_LIMIT = 50; // cycles allowed per handshake
	localparam int RUN_LIMIT = 100; // status polls per program
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;
	localparam opcodeT ARITH_OPS [5] = '{OP_ADD, OP_ADC, OP_SUB, OP_SUC, OP_CMP};
	localparam opcodeT LOGIC_OPS [6] = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHL, OP_SHR};
	localparam opcodeT JUMP_OPS [4] = '{OP_JC, OP_JNC, OP_JZ, OP_JNZ};

	logic clk;
	logic rst;
	logic [`CPU_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`CPU_AXI_DATA_W-1:0] wdata;
	logic [`CPU_AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`CPU_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`CPU_AXI_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [7:0] led;

	logic [15:0] prog [$]; // program image, word 0 upward
	string nameQ [$];
	logic [31:0] expQ [$];
	logic [31:0] actQ [$];
	int checkCount = 0;
	int errorCount = 0;
	int faultCount = 0; // timeouts and refused accesses

	cpuTop uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// expected result and {of, zf, cf} from the instruction rules
	function automatic logic [15:0] aluRef(input opcodeT op, input logic [15:0] a,
			input logic [15:0] b, input logic [2:0] fIn, output logic [2:0] fOut);
		int full;
		int sgn;
		int c;
		logic [15:0] r;
		c = (op == OP_ADC || op == OP_SUC) ? int'(fIn[0]) : 0;
		fOut = fIn;
		r = b;
		case (op)
			OP_ADD, OP_ADC: begin
				full = int'(a) + int'(b) + c;
				sgn = int'($signed(a)) + int'($signed(b)) + c;
				r = 16'(full);
				fOut = {(sgn > 32767 || sgn < -32768), (r == 16'h0), (full > 65535)};
			end
			OP_SUB, OP_SUC, OP_CMP: begin
				full = int'(a) - int'(b) - c;
				sgn = int'($signed(a)) - int'($signed(b)) - c;
				r = 16'(full);
				fOut = {(sgn > 32767 || sgn < -32768), (r == 16'h0), (full < 0)}; // borrow
			end
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_XOR: r = a ^ b;
			OP_NOT: r = ~a;
			OP_SHL: r = a << 1;
			OP_SHR: r = a >> 1;
			default: r = b;
		endcase
		return r;
	endfunction

	task automatic queueCheck(input string nm, input logic [31:0] expVal, input logic [31:0] actVal);
		nameQ.push_back(nm);
		expQ.push_back(expVal);
		actQ.push_back(actVal);
	endtask

	always @(posedge clk) begin : compare
		string nm;
		logic [31:0] e;
		logic [31:0] a;
		if (expQ.size() > 0) begin
			nm = nameQ.pop_front();
			e = expQ.pop_front();
			a = actQ.pop_front();
			checkCount++;
			assert (a === e) $display("ok    %s = %h", nm, a);
			else begin
				$display("ERROR %s: expected %h, actual %h", nm, e, a);
				errorCount++;
			end
		end
	end

	task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		logic seen;
		awaddr <= addr;
		wdata <= data;
		wstrb <= 4'hF;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		n = 0;
		seen = 1'b0;
		while (!seen && n < HS_LIMIT) begin
			@(posedge clk);
			seen = awready && wready;
			n++;
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		assert (seen) else begin
			$display("write to %h was never accepted", addr);
			faultCount++;
		end
		n = 0;
		seen = 1'b0;
		while (!seen && n < HS_LIMIT) begin
			@(posedge clk);
			seen = bvalid;
			n++;
		end
		resp = bresp;
		bready <= 1'b0;
		assert (seen) else begin
			$display("no write response for %h", addr);
			faultCount++;
		end
	endtask

	task automatic axiRead(input logic [15:0] addr, output logic [31:0] data);
		int n;
		logic seen;
		logic [1:0] resp;
		araddr <= addr;
		arvalid <= 1'b1;
		n = 0;
		seen = 1'b0;
		while (!seen && n < HS_LIMIT) begin
			@(posedge clk);
			seen = arready;
			n++;
		end
		arvalid <= 1'b0;
		rready <= 1'b1;
		assert (seen) else begin
			$display("read of %h was never accepted", addr);
			faultCount++;
		end
		n = 0;
		seen = 1'b0;
		while (!seen && n < HS_LIMIT) begin
			@(posedge clk);
			seen = rvalid;
			n++;
		end
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
		assert (seen) else begin
			$display("no read data for %h", addr);
			faultCount++;
		end
		assert (!seen || resp == OKAY) else begin
			$display("ERROR read of %h response: expected %h, actual %h", addr, OKAY, resp);
			faultCount++;
		end
	endtask

	task automatic waitHalted(output logic [31:0] status);
		int n;
		n = 0;
		status = '0;
		while (!status[1] && n < RUN_LIMIT) begin
			axiRead(`CPU_REG_STATUS, status);
			n++;
		end
		assert (status[1]) else begin
			$display("core did not halt");
			faultCount++;
		end
	endtask

	task automatic addInstr(input opcodeT op, input int len, input logic [15:0] p1,
			input logic [15:0] p2);
		prog.push_back(op);
		if (len > 1)
			prog.push_back(p1);
		if (len > 2)
			prog.push_back(p2);
	endtask

	task automatic loadProgram();
		logic [1:0] resp;
		foreach (prog[i]) begin
			axiWrite(`CPU_MEM_WIN + 16'(4 * i), {16'h0, prog[i]}, resp);
			assert (resp == OKAY) else begin
				$display("program load refused at word %0d", i);
				faultCount++;
			end
		end
	endtask

	task automatic loadAndRun(output logic [31:0] status);
		logic [1:0] resp;
		loadProgram();
		axiWrite(`CPU_REG_CTRL, 32'h1, resp);
		waitHalted(status);
	endtask

	task automatic checkResetState();
		logic [31:0] value;
		axiRead(`CPU_REG_STATUS, value);
		queueCheck("reset status", 32'h0, value);
		axiRead(`CPU_REG_LED, value);
		queueCheck("reset led", 32'h0, value);
		for (int r = 0; r < 4; r++) begin
			axiRead(`CPU_REG_GPR + 16'(4 * r), value);
			queueCheck($sformatf("reset reg %0d", r), 32'h0, value);
		end
	endtask

	// x + y sets the flags, then op works on ax and bx
	task automatic runOp(input opcodeT op, input logic [15:0] a, input logic [15:0] b,
			input logic [15:0] x, input logic [15:0] y, input string tag);
		logic [2:0] fPre;
		logic [2:0] fExp;
		logic [15:0] rExp;
		logic [31:0] status;
		logic [31:0] value;
		void'(aluRef(OP_ADD, x, y, 3'b000, fPre));
		rExp = aluRef(op, a, b, fPre, fExp);
		if (op == OP_CMP)
			rExp = a; // compare writes no register
		prog.delete();
		addInstr(OP_MOVI, 3, 16'(REG_AX), a);
		addInstr(OP_MOVI, 3, 16'(REG_BX), b);
		addInstr(OP_MOVI, 3, 16'(REG_CX), x);
		addInstr(OP_MOVI, 3, 16'(REG_DX), y);
		addInstr(OP_ADD, 2, {12'h0, REG_CX, REG_DX}, 16'h0);
		if (op inside {OP_NOT, OP_SHL, OP_SHR})
			addInstr(op, 2, 16'(REG_AX), 16'h0);
		else
			addInstr(op, 2, {12'h0, REG_AX, REG_BX}, 16'h0);
		addInstr(OP_HLT, 1, 16'h0, 16'h0);
		loadAndRun(status);
		queueCheck({tag, " status"}, {25'h0, fExp, 4'h2}, status);
		axiRead(`CPU_REG_GPR, value);
		queueCheck({tag, " ax"}, {16'h0, rExp}, value);
	endtask

	task automatic runMemory(input logic [15:0] v, input string tag);
		logic [31:0] status;
		logic [31:0] value;
		prog.delete();
		addInstr(OP_MOVI, 3, 16'(REG_BX), v);
		addInstr(OP_STA, 3, 16'(REG_BX), 16'h0300);
		addInstr(OP_LDA, 3, 16'(REG_CX), 16'h0300);
		addInstr(OP_MOVRR, 2, {12'h0, REG_DX, REG_CX}, 16'h0);
		addInstr(OP_OUT, 1, 16'h0, 16'h0);
		addInstr(OP_HLT, 1, 16'h0, 16'h0);
		loadAndRun(status);
		queueCheck({tag, " status"}, 32'h2, status);
		axiRead(`CPU_REG_GPR + 16'h8, value);
		queueCheck({tag, " cx"}, {16'h0, v}, value);
		axiRead(`CPU_REG_GPR + 16'hC, value);
		queueCheck({tag, " dx"}, {16'h0, v}, value);
		axiRead(`CPU_REG_LED, value);
		queueCheck({tag, " led reg"}, {24'h0, v[7:0]}, value);
		queueCheck({tag, " led pin"}, {24'h0, v[7:0]}, {24'h0, led});
	endtask

	task automatic runJump(input opcodeT op, input logic [15:0] p, input logic [15:0] q,
			input string tag);
		logic [2:0] f;
		logic taken;
		logic [31:0] status;
		logic [31:0] value;
		void'(aluRef(OP_SUB, p, q, 3'b000, f));
		case (op)
			OP_JC: taken = f[0];
			OP_JNC: taken = !f[0];
			OP_JZ: taken = f[1];
			default: taken = !f[1];
		endcase
		prog.delete();
		addInstr(OP_MOVI, 3, 16'(REG_BX), p);
		addInstr(OP_MOVI, 3, 16'(REG_CX), q);
		addInstr(OP_SUB, 2, {12'h0, REG_BX, REG_CX}, 16'h0);
		addInstr(op, 2, 16'd14, 16'h0);
		addInstr(OP_MOVI, 3, 16'(REG_AX), 16'h1111); // fall-through path
		addInstr(OP_HLT, 1, 16'h0, 16'h0);
		addInstr(OP_MOVI, 3, 16'(REG_AX), 16'h2222); // word 14, taken path
		addInstr(OP_HLT, 1, 16'h0, 16'h0);
		loadAndRun(status);
		axiRead(`CPU_REG_GPR, value);
		queueCheck({tag, " ax"}, taken ? 32'h2222 : 32'h1111, value);
	endtask

	task automatic runBusyRefusal();
		logic [31:0] value;
		logic [1:0] resp;
		prog.delete();
		addInstr(OP_JMP, 2, 16'h0, 16'h0); // spins forever
		loadProgram();
		axiWrite(`CPU_REG_CTRL, 32'h1, resp);
		axiRead(`CPU_REG_STATUS, value);
		queueCheck("busy status", 32'h1, value);
		axiWrite(`CPU_MEM_WIN + 16'h40, 32'h0000_BEEF, resp);
		queueCheck("busy load resp", {30'h0, SLVERR}, {30'h0, resp});
		axiRead(`CPU_REG_STATUS, value);
		queueCheck("busy still running", 32'h1, value);
		rst <= 1'b1;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		axiRead(`CPU_REG_STATUS, value);
		queueCheck("status after reset", 32'h0, value);
	endtask

	initial begin : main
		logic [15:0] a;
		logic [15:0] b;
		int n;
		void'($urandom(82378));
		rst <= 1'b1;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		checkResetState();
		foreach (ARITH_OPS[k]) begin
			runOp(ARITH_OPS[k], 16'h7FFF, 16'h0001, 16'hFFFF, 16'h0001,
				$sformatf("%s_0", ARITH_OPS[k].name()));
			runOp(ARITH_OPS[k], 16'h8000, 16'h0001, 16'h0000, 16'h0000,
				$sformatf("%s_1", ARITH_OPS[k].name()));
			for (int i = 2; i < 4; i++)
				runOp(ARITH_OPS[k], $urandom, $urandom, $urandom, $urandom,
					$sformatf("%s_%0d", ARITH_OPS[k].name(), i));
		end
		foreach (LOGIC_OPS[k]) begin
			for (int i = 0; i < 2; i++)
				runOp(LOGIC_OPS[k], $urandom, $urandom, $urandom, $urandom,
					$sformatf("%s_%0d", LOGIC_OPS[k].name(), i));
		end
		for (int i = 0; i < 2; i++)
			runMemory($urandom, $sformatf("mem_%0d", i));
		foreach (JUMP_OPS[k]) begin
			a = $urandom;
			b = a & 16'h7FFF;
			runJump(JUMP_OPS[k], a, a, $sformatf("%s_eq", JUMP_OPS[k].name()));
			runJump(JUMP_OPS[k], b, b + 16'h1, $sformatf("%s_lt", JUMP_OPS[k].name()));
		end
		runBusyRefusal();

		n = 0;
		while (expQ.size() > 0 && n < HS_LIMIT) begin
			@(posedge clk);
			n++;
		end
		assert (expQ.size() == 0) else begin
			$display("compare queue did not drain");
			faultCount++;
		end
		$display("checks %0d, mismatches %0d, faults %0d, assertion failures %0d",
			checkCount, errorCount, faultCount, uut.uChk.failCount);
		if (errorCount == 0 && faultCount == 0 && uut.uChk.failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
cpu_pkg.sv
aluUnit.sv
progMem.sv
hostCtrl.sv
cpuCore.sv
cpuTop.sv
cpu_chk.sv
cpu_tb.sv
